/* mini_mcu.f */
common/mcu_pkg.sv
common/obi_if.sv
src/sram_bank.sv
src/obi_arbiter.sv
cpu_subsystem/cpu_subsystem.sv
src/mini_mcu.sv
verif/mcu_checker.sv
verif/tb_mini_mcu.sv

/* Makefile */
# Verilator build, run and lint for the mini MCU

VERILATOR ?= verilator
TOP       ?= tb_mini_mcu
LINT_TOP  ?= mini_mcu
FILELIST  ?= mini_mcu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_LINE ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_LINE)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* verif/tb_mini_mcu.sv */
//////////////////////////////
// Mini MCU testbench
// Program load, irq stimulus, ext traffic
//////////////////////////////

`timescale 1ns/1ps

module tb_mini_mcu;
    import mcu_pkg::*;

    localparam int RST_CYCLES = 8;
    localparam int MEM_N = 8;
    localparam int BG_N = 6;
    localparam int RESULT_N = 9;
    localparam int PROG_MAX = 48;
    localparam int ACCESS_CYCLES = 4;

    logic              clk;
    logic              rst_n;
    logic              fetch_enable;
    logic [31:0]       irq;
    logic              irq_ack;
    logic [4:0]        irq_id;
    logic              core_sleep;
    logic              core_halted;
    logic              ext_req;
    logic              ext_we;
    logic [ADDR_W-1:0] ext_addr;
    logic [3:0]        ext_be;
    logic [31:0]       ext_wdata;
    logic              ext_gnt;
    logic              ext_rvalid;
    logic [31:0]       ext_rdata;
    int                model_steps;
    int                checks;
    int                errors;
    logic [31:0]       lfsr;
    logic [ADDR_W-1:0] asm_pc;

    mini_mcu i_mini_mcu (
        .clk_i(clk), .rst_n_i(rst_n), .fetch_enable_i(fetch_enable), .irq_i(irq),
        .irq_ack_o(irq_ack), .irq_id_o(irq_id), .core_sleep_o(core_sleep),
        .core_halted_o(core_halted), .ext_req_i(ext_req), .ext_we_i(ext_we),
        .ext_addr_i(ext_addr), .ext_be_i(ext_be), .ext_wdata_i(ext_wdata),
        .ext_gnt_o(ext_gnt), .ext_rvalid_o(ext_rvalid), .ext_rdata_o(ext_rdata)
    );

    mcu_checker i_mcu_checker (
        .clk_i(clk), .rst_n_i(rst_n), .fetch_enable_i(fetch_enable), .irq_i(irq),
        .irq_ack_i(irq_ack), .irq_id_i(irq_id), .core_sleep_i(core_sleep),
        .core_halted_i(core_halted), .ext_req_i(ext_req), .ext_we_i(ext_we),
        .ext_addr_i(ext_addr), .ext_be_i(ext_be), .ext_wdata_i(ext_wdata),
        .ext_gnt_i(ext_gnt), .ext_rvalid_i(ext_rvalid), .ext_rdata_i(ext_rdata),
        .steps_o(model_steps), .checks_o(checks), .errors_o(errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // One access, held until granted, then waits for its response
    task automatic ext_access(input logic [ADDR_W-1:0] addr, input logic we,
                              input logic [3:0] be, input logic [31:0] wdata);
        ext_req   <= 1'b1;
        ext_we    <= we;
        ext_addr  <= addr;
        ext_be    <= be;
        ext_wdata <= wdata;
        do begin
            @(posedge clk);
        end while (!ext_gnt);
        ext_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (!ext_rvalid);
    endtask

    task automatic emit(input opcode_e op, input logic [15:0] opnd);
        ext_access(asm_pc, 1'b1, 4'hF, {op, 12'h000, opnd});
        asm_pc = asm_pc + 1'b1;
    endtask

    initial begin : stimulus
        logic [31:0]       vec;
        logic [ADDR_W-1:0] loop_pc;
        lfsr = 32'h64be2591;
        rst_n = 1'b0;
        fetch_enable = 1'b0;
        irq = '0;
        ext_req = 1'b0;
        ext_we = 1'b0;
        ext_addr = '0;
        ext_be = '0;
        ext_wdata = '0;
        asm_pc = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Full word, then a random byte merge, then read back
        for (int i = 0; i < MEM_N; i++) begin
            ext_access(ADDR_W'(900 + i), 1'b1, 4'hF, lfsr_bits(32));
            ext_access(ADDR_W'(900 + i), 1'b1, 4'(lfsr_bits(4)), lfsr_bits(32));
            ext_access(ADDR_W'(900 + i), 1'b0, 4'hF, '0);
        end

        // Operands for LD
        ext_access(ADDR_W'(128), 1'b1, 4'hF, lfsr_bits(32));
        ext_access(ADDR_W'(129), 1'b1, 4'hF, lfsr_bits(32));

        // ALU section, results at 160 to 163
        emit(LDI, 16'(lfsr_bits(16)));
        emit(ADD, 16'(lfsr_bits(16)));
        emit(ST, 16'd160);
        emit(LD, 16'd128);
        emit(SUB, 16'(lfsr_bits(16)));
        emit(ST, 16'd161);
        emit(LD, 16'd129);
        emit(AND, 16'(lfsr_bits(16)));
        emit(ST, 16'd163);
        emit(OR, 16'(lfsr_bits(16)));
        emit(NOP, 16'd0);
        emit(XOR, 16'(lfsr_bits(16)));
        emit(SHL, 16'(lfsr_bits(5)));
        emit(ST, 16'd162);

        // Countdown loop, trip count kept at 164
        emit(LDI, 16'd0);
        emit(ST, 16'd164);
        emit(LDI, 16'(lfsr_bits(3) + 3));
        loop_pc = asm_pc;
        emit(ST, 16'd165);
        emit(LD, 16'd164);
        emit(ADD, 16'd1);
        emit(ST, 16'd164);
        emit(LD, 16'd165);
        emit(SUB, 16'd1);
        emit(BEQZ, 16'(loop_pc + 8));
        emit(JMP, 16'(loop_pc));
        emit(XOR, 16'(lfsr_bits(16)));
        emit(ST, 16'd166);

        // Sleep, then one store after the return
        emit(WAIT, 16'd0);
        emit(LDI, 16'(lfsr_bits(16)));
        emit(ST, 16'd167);
        emit(HALT, 16'd0);

        // Handler leaves a marker
        asm_pc = ADDR_W'(IRQ_VECTOR);
        emit(LDI, 16'hC0DE);
        emit(ST, 16'd168);
        emit(RETI, 16'd0);

        fetch_enable <= 1'b1;
        // Ext writes that compete with the running core
        for (int i = 0; i < BG_N; i++) begin
            ext_access(ADDR_W'(512 + i), 1'b1, 4'hF, lfsr_bits(32));
        end

        vec = lfsr_bits(32) & (32'hFFFF_FFFF << lfsr_bits(5));
        if (vec == '0) begin
            vec = 32'h8000_0000;
        end
        do begin
            @(posedge clk);
        end while (!core_sleep);
        irq <= vec;
        do begin
            @(posedge clk);
        end while (!irq_ack);
        // Line stays up a little past the ack
        repeat (2) @(posedge clk);
        irq <= '0;
        do begin
            @(posedge clk);
        end while (!core_halted);

        for (int i = 0; i < RESULT_N; i++) begin
            ext_access(ADDR_W'(160 + i), 1'b0, 4'hF, '0);
        end
        for (int i = 0; i < BG_N; i++) begin
            ext_access(ADDR_W'(512 + i), 1'b0, 4'hF, '0);
        end
        for (int i = 0; i < MEM_N; i++) begin
            ext_access(ADDR_W'(900 + i), 1'b0, 4'hF, '0);
        end

        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Loading bound first, then model length times 10 cycles
    initial begin : watchdog
        int unsigned limit;
        int unsigned waited;
        limit = RST_CYCLES + ACCESS_CYCLES * (3 * MEM_N + 2 + PROG_MAX) + 20;
        waited = 0;
        while (!fetch_enable && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (!fetch_enable) begin
            $display("Watchdog: program loading did not finish in %0d cycles", limit);
            $display("RESULT: FAIL");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            limit = model_steps * 10 + ACCESS_CYCLES * (2 * BG_N + RESULT_N + MEM_N) + 20;
            repeat (limit) @(posedge clk);
            $display("Watchdog: run did not finish in %0d cycles after fetch enable", limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

/* verif/mcu_checker.sv */
//////////////////////////////
// Mini MCU checker
// ISA reference model and ext port scoreboard
//////////////////////////////

`timescale 1ns/1ps

module mcu_checker (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       fetch_enable_i,
    input  logic [31:0]                irq_i,
    input  logic                       irq_ack_i,
    input  logic [4:0]                 irq_id_i,
    input  logic                       core_sleep_i,
    input  logic                       core_halted_i,
    input  logic                       ext_req_i,
    input  logic                       ext_we_i,
    input  logic [mcu_pkg::ADDR_W-1:0] ext_addr_i,
    input  logic [3:0]                 ext_be_i,
    input  logic [31:0]                ext_wdata_i,
    input  logic                       ext_gnt_i,
    input  logic                       ext_rvalid_i,
    input  logic [31:0]                ext_rdata_i,
    output int                         steps_o,
    output int                         checks_o,
    output int                         errors_o
);
    import mcu_pkg::*;

    // Shadow of the SRAM, built from ext writes and model stores
    logic [31:0]       model_mem [MEM_WORDS];
    logic [31:0]       exp_q;
    logic [ADDR_W-1:0] addr_q;
    logic              gnt_q;
    logic              read_q;
    logic              fe_q;
    logic              ack_q;
    logic              halted_q;
    int                model_waits;
    int                acks;

    function automatic void report_error(input string msg);
        errors_o++;
        $display("** Error at %0t ns: %s", $time, msg);
    endfunction

    // Counting up from bit 0
    function automatic logic [4:0] lowest_set(input logic [31:0] v);
        for (int i = 0; i < 32; i++) begin
            if (v[i]) begin
                return 5'(i);
            end
        end
        return 5'd0;
    endfunction

    // Runs the shadow image to HALT, returns the instruction count
    function automatic int run_model();
        logic [31:0]       acc;
        logic [31:0]       ir;
        logic [31:0]       imm;
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] ret;
        int                steps;
        bit                done;
        acc = '0;
        pc = ADDR_W'(BOOT_WORD);
        ret = '0;
        steps = 0;
        done = 1'b0;
        model_waits = 0;
        while (!done && steps < 4096) begin
            ir = model_mem[pc];
            imm = {16'h0000, ir[15:0]};
            pc = pc + 1'b1;
            steps++;
            case (opcode_e'(ir[31:28]))
                NOP:  ;
                LDI:  acc = imm;
                LD:   acc = model_mem[ir[ADDR_W-1:0]];
                ST:   model_mem[ir[ADDR_W-1:0]] = acc;
                ADD:  acc = acc + imm;
                SUB:  acc = acc - imm;
                AND:  acc = acc & imm;
                OR:   acc = acc | imm;
                XOR:  acc = acc ^ imm;
                SHL:  acc = acc << ir[4:0];
                BEQZ: pc = (acc == '0) ? ir[ADDR_W-1:0] : pc;
                JMP:  pc = ir[ADDR_W-1:0];
                // Interrupt is taken right after WAIT
                WAIT: begin
                    ret = pc;
                    pc = ADDR_W'(IRQ_VECTOR);
                    model_waits++;
                end
                RETI: pc = ret;
                HALT: done = 1'b1;
                default: begin
                    report_error($sformatf("model fetched bad word %h", ir));
                    done = 1'b1;
                end
            endcase
        end
        if (!done) begin
            report_error("reference model did not reach HALT");
        end
        return steps;
    endfunction

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            gnt_q = 1'b0;
            read_q = 1'b0;
            fe_q = 1'b0;
            ack_q = 1'b0;
            halted_q = 1'b0;
            acks = 0;
            steps_o = 0;
            checks_o = 0;
            errors_o = 0;
        end else begin
            // Ext port is top priority, grant in the request cycle
            if (ext_req_i) begin
                checks_o++;
                if (!ext_gnt_i) begin
                    report_error("ext request not granted in its own cycle");
                end
            end
            if (ext_rvalid_i !== gnt_q) begin
                report_error($sformatf("ext rvalid %b, expected %b", ext_rvalid_i, gnt_q));
            end
            if (ext_rvalid_i && read_q) begin
                checks_o++;
                if (ext_rdata_i !== exp_q) begin
                    report_error($sformatf("word %0d read %h, expected %h",
                                           addr_q, ext_rdata_i, exp_q));
                end
            end
            gnt_q = ext_req_i;
            read_q = gnt_q && !ext_we_i;
            if (gnt_q) begin
                addr_q = ext_addr_i;
                exp_q = model_mem[ext_addr_i];
                for (int b = 0; b < 4; b++) begin
                    if (ext_we_i && ext_be_i[b]) begin
                        model_mem[ext_addr_i][8*b +: 8] = ext_wdata_i[8*b +: 8];
                    end
                end
            end

            if (irq_ack_i) begin
                acks++;
                checks_o++;
                if (ack_q) begin
                    report_error("irq_ack_o high for two cycles in a row");
                end
                if (!core_sleep_i) begin
                    report_error("interrupt taken while the core was not in WAIT");
                end
                if (irq_id_i !== lowest_set(irq_i)) begin
                    report_error($sformatf("irq_id %0d for irq %h, expected %0d",
                                           irq_id_i, irq_i, lowest_set(irq_i)));
                end
            end
            ack_q = irq_ack_i;

            // Image is complete once fetch enable rises
            if (fetch_enable_i && !fe_q) begin
                steps_o = run_model();
            end
            fe_q = fetch_enable_i;

            if (core_halted_i && !halted_q) begin
                checks_o++;
                if (acks != model_waits) begin
                    report_error($sformatf("%0d irq acks, expected %0d", acks, model_waits));
                end
            end
            if (halted_q && !core_halted_i) begin
                report_error("core_halted_o dropped before reset");
            end
            halted_q = halted_q || core_halted_i;
        end
    end

endmodule

/* src/mini_mcu.sv */
//////////////////////////////
// Mini MCU top level
// Core, arbiter and SRAM bank
//////////////////////////////

`timescale 1ns/1ps

module mini_mcu (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      fetch_enable_i,
    input  logic [31:0]               irq_i,
    output logic                      irq_ack_o,
    output logic [4:0]                irq_id_o,
    output logic                      core_sleep_o,
    output logic                      core_halted_o,

    // External loader port
    input  logic                      ext_req_i,
    input  logic                      ext_we_i,
    input  logic [mcu_pkg::ADDR_W-1:0] ext_addr_i,
    input  logic [3:0]                ext_be_i,
    input  logic [31:0]               ext_wdata_i,
    output logic                      ext_gnt_o,
    output logic                      ext_rvalid_o,
    output logic [31:0]               ext_rdata_o
);

    obi_if instr_bus ();
    obi_if data_bus ();
    obi_if ext_bus ();
    obi_if mem_bus ();

    // Loader pins onto the ext master bus
    assign ext_bus.req   = ext_req_i;
    assign ext_bus.we    = ext_we_i;
    assign ext_bus.addr  = ext_addr_i;
    assign ext_bus.be    = ext_be_i;
    assign ext_bus.wdata = ext_wdata_i;
    assign ext_gnt_o     = ext_bus.gnt;
    assign ext_rvalid_o  = ext_bus.rvalid;
    assign ext_rdata_o   = ext_bus.rdata;

    cpu_subsystem i_cpu_subsystem (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fetch_enable_i (fetch_enable_i),
        .instr_o        (instr_bus),
        .data_o         (data_bus),
        .irq_i          (irq_i),
        .irq_ack_o      (irq_ack_o),
        .irq_id_o       (irq_id_o),
        .core_sleep_o   (core_sleep_o),
        .core_halted_o  (core_halted_o)
    );

    obi_arbiter i_obi_arbiter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ext_i   (ext_bus),
        .data_i  (data_bus),
        .instr_i (instr_bus),
        .mem_o   (mem_bus)
    );

    sram_bank i_sram_bank (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus_i   (mem_bus)
    );

endmodule

/* cpu_subsystem/cpu_subsystem.sv */
//////////////////////////////
// Accumulator CPU core
// OBI fetch and data ports, sleep and irq entry
//////////////////////////////

`timescale 1ns/1ps

module cpu_subsystem (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        fetch_enable_i,
    obi_if.master       instr_o,
    obi_if.master       data_o,
    input  logic [31:0] irq_i,
    output logic        irq_ack_o,
    output logic [4:0]  irq_id_o,
    output logic        core_sleep_o,
    output logic        core_halted_o
);
    import mcu_pkg::*;

    cpu_state_e        state_q;
    logic [ADDR_W-1:0] pc_q;
    logic [ADDR_W-1:0] ret_q;
    logic [31:0]       acc_q;
    logic [31:0]       ir_q;

    opcode_e           op;
    logic [OPND_W-1:0] opnd;
    logic [31:0]       imm;
    logic [ADDR_W-1:0] target;
    logic [ADDR_W-1:0] pc_next;
    logic              irq_take;
    logic [4:0]        irq_lowest;

    // Decode of the held instruction
    assign op      = opcode_e'(ir_q[31:28]);
    assign opnd    = ir_q[OPND_W-1:0];
    assign imm     = {{(32 - OPND_W){1'b0}}, opnd};
    assign target  = opnd[ADDR_W-1:0];
    assign pc_next = pc_q + 1'b1;

    // Instruction port only ever reads
    assign instr_o.req   = (state_q == FETCH);
    assign instr_o.addr  = pc_q;
    assign instr_o.we    = 1'b0;
    assign instr_o.be    = BE_ALL;
    assign instr_o.wdata = '0;

    // Data port, word accesses for LD and ST
    assign data_o.req   = (state_q == MEM);
    assign data_o.addr  = target;
    assign data_o.we    = (op == ST);
    assign data_o.be    = BE_ALL;
    assign data_o.wdata = acc_q;

    // Lowest set irq bit wins
    always_comb begin
        irq_lowest = '0;
        for (int i = 31; i >= 0; i--) begin
            if (irq_i[i]) begin
                irq_lowest = 5'(i);
            end
        end
    end

    // Interrupts are only taken from WAIT, so the ack lasts one cycle
    assign irq_take      = (state_q == SLEEP) && (|irq_i);
    assign irq_ack_o     = irq_take;
    assign irq_id_o      = irq_take ? irq_lowest : 5'd0;
    assign core_sleep_o  = (state_q == SLEEP);
    assign core_halted_o = (state_q == HALTED);

    // Sequencer, PC and accumulator
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            pc_q    <= ADDR_W'(BOOT_WORD);
            acc_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (fetch_enable_i) begin
                        state_q <= FETCH;
                        pc_q    <= ADDR_W'(BOOT_WORD);
                    end
                end
                FETCH: begin
                    if (instr_o.gnt) begin
                        state_q <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (instr_o.rvalid) begin
                        state_q <= EXEC;
                    end
                end
                EXEC: begin
                    // PC moves on here, memory ops included
                    state_q <= FETCH;
                    pc_q    <= pc_next;
                    case (op)
                        LDI:     acc_q <= imm;
                        LD, ST:  state_q <= MEM;
                        ADD:     acc_q <= acc_q + imm;
                        SUB:     acc_q <= acc_q - imm;
                        AND:     acc_q <= acc_q & imm;
                        OR:      acc_q <= acc_q | imm;
                        XOR:     acc_q <= acc_q ^ imm;
                        SHL:     acc_q <= acc_q << opnd[4:0];
                        BEQZ: begin
                            if (acc_q == '0) begin
                                pc_q <= target;
                            end
                        end
                        JMP:     pc_q <= target;
                        WAIT:    state_q <= SLEEP;
                        RETI:    pc_q <= ret_q;
                        HALT:    state_q <= HALTED;
                        default: ;
                    endcase
                end
                MEM: begin
                    if (data_o.gnt) begin
                        state_q <= MEM_WAIT;
                    end
                end
                MEM_WAIT: begin
                    if (data_o.rvalid) begin
                        if (op == LD) begin
                            acc_q <= data_o.rdata;
                        end
                        state_q <= FETCH;
                    end
                end
                SLEEP: begin
                    if (irq_take) begin
                        pc_q    <= ADDR_W'(IRQ_VECTOR);
                        state_q <= FETCH;
                    end
                end
                HALTED:  ;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Instruction register and return address
    always_ff @(posedge clk_i) begin
        if ((state_q == FETCH_WAIT) && instr_o.rvalid) begin
            ir_q <= instr_o.rdata;
        end
        // pc_q already points past WAIT
        if (irq_take) begin
            ret_q <= pc_q;
        end
    end

    // Stalled requests hold still until the arbiter grants
    a_instr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_o.req && !instr_o.gnt |=> instr_o.req && $stable(instr_o.addr))
        else $error("instr request changed before grant");

    a_data_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_o.req && !data_o.gnt |=> data_o.req &&
        $stable({data_o.addr, data_o.we, data_o.be, data_o.wdata}))
        else $error("data request changed before grant");

    a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_ack_o |=> !irq_ack_o)
        else $error("irq_ack_o held for more than one cycle");

endmodule

/* src/obi_arbiter.sv */
//////////////////////////////
// Fixed-priority OBI arbiter
// Three masters onto one bank
//////////////////////////////

`timescale 1ns/1ps

module obi_arbiter (
    input  logic  clk_i,
    input  logic  rst_n_i,
    obi_if.slave  ext_i,
    obi_if.slave  data_i,
    obi_if.slave  instr_i,
    obi_if.master mem_o
);
    import mcu_pkg::*;

    master_e sel;
    master_e owner_q;

    // Priority: ext, data, instr
    always_comb begin
        if (ext_i.req) begin
            sel = M_EXT;
        end else if (data_i.req) begin
            sel = M_DATA;
        end else begin
            sel = M_INSTR;
        end
    end

    // Chosen master drives the bank
    always_comb begin
        mem_o.req = ext_i.req | data_i.req | instr_i.req;
        case (sel)
            M_EXT: begin
                mem_o.addr  = ext_i.addr;
                mem_o.we    = ext_i.we;
                mem_o.be    = ext_i.be;
                mem_o.wdata = ext_i.wdata;
            end
            M_DATA: begin
                mem_o.addr  = data_i.addr;
                mem_o.we    = data_i.we;
                mem_o.be    = data_i.be;
                mem_o.wdata = data_i.wdata;
            end
            default: begin
                mem_o.addr  = instr_i.addr;
                mem_o.we    = instr_i.we;
                mem_o.be    = instr_i.be;
                mem_o.wdata = instr_i.wdata;
            end
        endcase
    end

    assign ext_i.gnt   = ext_i.req && mem_o.gnt;
    assign data_i.gnt  = data_i.req && !ext_i.req && mem_o.gnt;
    assign instr_i.gnt = instr_i.req && !ext_i.req && !data_i.req && mem_o.gnt;

    // Owner of the response due next cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            owner_q <= M_EXT;
        end else if (mem_o.req && mem_o.gnt) begin
            owner_q <= sel;
        end
    end

    assign ext_i.rvalid   = mem_o.rvalid && (owner_q == M_EXT);
    assign data_i.rvalid  = mem_o.rvalid && (owner_q == M_DATA);
    assign instr_i.rvalid = mem_o.rvalid && (owner_q == M_INSTR);
    assign ext_i.rdata    = (owner_q == M_EXT) ? mem_o.rdata : '0;
    assign data_i.rdata   = (owner_q == M_DATA) ? mem_o.rdata : '0;
    assign instr_i.rdata  = (owner_q == M_INSTR) ? mem_o.rdata : '0;

    a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({ext_i.gnt, data_i.gnt, instr_i.gnt}))
        else $error("more than one master granted");

    // Responses go back only to last cycle's winner
    a_ext_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ext_i.rvalid |-> $past(ext_i.gnt))
        else $error("ext rvalid without grant");
    a_data_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_i.rvalid |-> $past(data_i.gnt))
        else $error("data rvalid without grant");
    a_instr_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_i.rvalid |-> $past(instr_i.gnt))
        else $error("instr rvalid without grant");

endmodule

/* src/sram_bank.sv */
//////////////////////////////
// Single-port SRAM bank
// Byte writes, one-cycle reads
//////////////////////////////

`timescale 1ns/1ps

module sram_bank (
    input  logic clk_i,
    input  logic rst_n_i,
    obi_if.slave bus_i
);
    import mcu_pkg::*;

    logic [31:0] mem_q [MEM_WORDS];
    logic [31:0] rdata_q;
    logic        rvalid_q;

    // Never busy, so any request is taken at once
    assign bus_i.gnt    = bus_i.req;
    assign bus_i.rvalid = rvalid_q;
    assign bus_i.rdata  = rdata_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus_i.req && bus_i.gnt;
        end
    end

    // A write answers with the word it replaces
    always_ff @(posedge clk_i) begin
        if (bus_i.req) begin
            rdata_q <= mem_q[bus_i.addr];
            if (bus_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus_i.be[b]) begin
                        mem_q[bus_i.addr][8*b +: 8] <= bus_i.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

/* common/obi_if.sv */
//////////////////////////////
// OBI request/response bundle
//////////////////////////////

`timescale 1ns/1ps

interface obi_if;
    import mcu_pkg::*;

    // Request side
    logic              req;
    logic              gnt;
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [3:0]        be;
    logic [31:0]       wdata;

    // Response side, one cycle after grant
    logic              rvalid;
    logic [31:0]       rdata;

    modport master (
        output req,
        output addr,
        output we,
        output be,
        output wdata,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport slave (
        input  req,
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

/* common/mcu_pkg.sv */
//////////////////////////////
// MCU shared definitions
// Memory map, ISA and bus ids
//////////////////////////////

package mcu_pkg;

    // Memory geometry
    localparam int MEM_WORDS = 1024;
    localparam int ADDR_W = 10;

    // Reset and interrupt entry points, in words
    localparam int BOOT_WORD = 0;
    localparam int IRQ_VECTOR = 64;

    // Instruction word layout
    localparam int OPND_W = 16;
    localparam logic [3:0] BE_ALL = 4'b1111;

    // Opcodes live in bits 31:28
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        LDI  = 4'd1,
        LD   = 4'd2,
        ST   = 4'd3,
        ADD  = 4'd4,
        SUB  = 4'd5,
        AND  = 4'd6,
        OR   = 4'd7,
        XOR  = 4'd8,
        SHL  = 4'd9,
        BEQZ = 4'd10,
        JMP  = 4'd11,
        WAIT = 4'd12,
        RETI = 4'd13,
        HALT = 4'd14
    } opcode_e;

    // Core sequencer
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        FETCH_WAIT,
        EXEC,
        MEM,
        MEM_WAIT,
        SLEEP,
        HALTED
    } cpu_state_e;

    // Arbiter masters, highest priority first
    typedef enum logic [1:0] {
        M_EXT   = 2'd0,
        M_DATA  = 2'd1,
        M_INSTR = 2'd2
    } master_e;

endpackage
